/* filelist.f */
issue_pkg.sv
issue_regfile.sv
issue_scoreboard.sv
issue_operand_sel.sv
issue_ctrl.sv
issue_stage.sv
issue_chk.sv
tb_issue.sv

/* run.sh */
#!/bin/sh
# Build the issue stage testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -Wno-fatal --top-module tb_issue \
	-f filelist.f -o sim_issue \
	&& ./obj_dir/sim_issue | tee /dev/stderr | grep -qF "=== PASS ===" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* tb_issue.sv */
// --------------------------------------------------------------------------
// Random testbench of the issue stage. A scoreboard model predicts issue
// strobes and operands, which are compared at each falling clock edge.
// --------------------------------------------------------------------------
`default_nettype none

module tb_issue;

	localparam int NUM_CYCLES     = 600;
	localparam int TIMEOUT_CYCLES = 2 * (NUM_CYCLES + 3);

	logic clk;
	logic rst_n;
	// Decode queue slots with index 0 the older one
	logic                valid [2];
	logic                instr_valid [2];
	logic                src1_is_pc [2];
	logic                src2_is_imm [2];
	issue_pkg::preg_t    src1 [2];
	issue_pkg::preg_t    src2 [2];
	issue_pkg::preg_t    dst [2];
	issue_pkg::ticket_t  ticket [2];
	issue_pkg::fu_t      fu [2];
	issue_pkg::word_t    pc [2];
	issue_pkg::word_t    imm [2];
	// Commit ports
	logic                wb_valid [2];
	logic                wb_flushed [2];
	issue_pkg::preg_t    wb_dst [2];
	issue_pkg::ticket_t  wb_ticket [2];
	issue_pkg::word_t    wb_data [2];
	logic               [issue_pkg::FU_NUM-1:0]        fu_valid;
	issue_pkg::preg_t   [issue_pkg::FU_NUM-1:0]        fu_dst;
	issue_pkg::ticket_t [issue_pkg::FU_NUM-1:0]        fu_ticket;
	issue_pkg::word_t   [issue_pkg::FU_NUM-1:0]        fu_data;
	logic               [issue_pkg::FU_NUM-1:0]        busy_fu;
	issue_pkg::ticket_t [issue_pkg::RF_READ_PORTS-1:0] rob_addr;
	issue_pkg::word_t   [issue_pkg::RF_READ_PORTS-1:0] rob_data;
	logic                                              flush_valid;
	logic               [issue_pkg::ROB_DEPTH-1:0]     flush_keep;
	logic                issue_1;
	logic                issue_2;
	issue_pkg::word_t    op_a_1;
	issue_pkg::word_t    op_b_1;
	issue_pkg::word_t    op_a_2;
	issue_pkg::word_t    op_b_2;

	// Reference model state
	issue_pkg::word_t                m_rf [issue_pkg::NUM_PREGS];
	logic [issue_pkg::NUM_PREGS-1:0] m_pending;
	logic [issue_pkg::NUM_PREGS-1:0] m_in_rob;
	issue_pkg::ticket_t              m_ticket [issue_pkg::NUM_PREGS];
	issue_pkg::fu_t                  m_fu [issue_pkg::NUM_PREGS];
	logic                            pop_1;
	logic                            pop_2;
	logic [31:0]                     lfsr;
	int                              cycles;

	issue_stage i_dut (
		.clk (clk), .rst_n (rst_n),
		.valid_1 (valid[0]), .instr_valid_1 (instr_valid[0]),
		.src1_1 (src1[0]), .src2_1 (src2[0]), .dst_1 (dst[0]),
		.ticket_1 (ticket[0]), .fu_1 (fu[0]), .pc_1 (pc[0]), .imm_1 (imm[0]),
		.src1_is_pc_1 (src1_is_pc[0]), .src2_is_imm_1 (src2_is_imm[0]),
		.valid_2 (valid[1]), .instr_valid_2 (instr_valid[1]),
		.src1_2 (src1[1]), .src2_2 (src2[1]), .dst_2 (dst[1]),
		.ticket_2 (ticket[1]), .fu_2 (fu[1]), .pc_2 (pc[1]), .imm_2 (imm[1]),
		.src1_is_pc_2 (src1_is_pc[1]), .src2_is_imm_2 (src2_is_imm[1]),
		.issue_1 (issue_1), .issue_2 (issue_2),
		.op_a_1 (op_a_1), .op_b_1 (op_b_1), .op_a_2 (op_a_2), .op_b_2 (op_b_2),
		.wb_valid_1 (wb_valid[0]), .wb_flushed_1 (wb_flushed[0]),
		.wb_dst_1 (wb_dst[0]), .wb_ticket_1 (wb_ticket[0]), .wb_data_1 (wb_data[0]),
		.wb_valid_2 (wb_valid[1]), .wb_flushed_2 (wb_flushed[1]),
		.wb_dst_2 (wb_dst[1]), .wb_ticket_2 (wb_ticket[1]), .wb_data_2 (wb_data[1]),
		.fu_valid (fu_valid), .fu_dst (fu_dst), .fu_ticket (fu_ticket),
		.fu_data (fu_data), .busy_fu (busy_fu),
		.rob_addr (rob_addr), .rob_data (rob_data),
		.flush_valid (flush_valid), .flush_keep (flush_keep)
	);

	// 32-bit Fibonacci LFSR with taps 32 22 2 1
	function automatic logic next_bit();
		logic nb;
		nb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], nb};
		return nb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], next_bit()};
		end
		return v;
	endfunction

	// ROB contents as a function of the ticket
	function automatic issue_pkg::word_t rob_word(input issue_pkg::ticket_t t);
		return {16'hb0b0, 13'd0, t};
	endfunction

	always_comb begin
		for (int k = 0; k < issue_pkg::RF_READ_PORTS; k++) begin
			rob_data[k] = rob_word(rob_addr[k]);
		end
	end

	function automatic void expect_operand(input logic special,
		input issue_pkg::word_t special_val, input issue_pkg::preg_t src,
		output logic ok, output issue_pkg::word_t val);
		issue_pkg::fu_t unit;
		unit = m_fu[src];
		ok   = 1'b1;
		val  = m_rf[src];
		if (special) begin
			val = special_val;
		end else if (m_pending[src]) begin
			if (m_in_rob[src]) begin
				val = rob_word(m_ticket[src]);
			end else if (fu_valid[unit] && fu_dst[unit] == src) begin
				val = fu_data[unit];
			end else begin
				ok = 1'b0;
			end
		end
	endfunction

	// Expected strobes and operands from the current inputs and the model
	function automatic void expect_issue(output logic exp_1, output logic exp_2,
		output issue_pkg::word_t [3:0] ops);
		logic             ok_a;
		logic             ok_b;
		issue_pkg::word_t val_a;
		issue_pkg::word_t val_b;
		logic [1:0]       own;
		logic             dep;
		for (int s = 0; s < 2; s++) begin
			expect_operand(src1_is_pc[s], pc[s], src1[s], ok_a, val_a);
			expect_operand(src2_is_imm[s], imm[s], src2[s], ok_b, val_b);
			ops[2*s]   = val_a;
			ops[2*s+1] = val_b;
			own[s] = valid[s] && instr_valid[s] && !busy_fu[fu[s]] &&
				!m_pending[dst[s]] && ok_a && ok_b;
		end
		dep   = (dst[0] != '0) && ((src1[1] == dst[0]) || (src2[1] == dst[0]));
		exp_1 = own[0];
		exp_2 = own[0] && own[1] && !dep && (fu[0] != fu[1]);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("Mismatch %s: got %h, expected %h", name, got, expected);
			$display("=== FAIL ===");
			$fatal(1, "compare failed");
		end
	endtask

	task automatic new_slot(input int s);
		valid[s]       = rand_bits(3) != 0;
		instr_valid[s] = rand_bits(3) != 0;
		src1[s]        = issue_pkg::preg_t'(rand_bits(3));
		src2[s]        = issue_pkg::preg_t'(rand_bits(3));
		dst[s]         = issue_pkg::preg_t'(rand_bits(3));
		ticket[s]      = issue_pkg::ticket_t'(rand_bits(3));
		fu[s]          = issue_pkg::fu_t'(rand_bits(2));
		pc[s]          = rand_bits(32);
		imm[s]         = rand_bits(32);
		src1_is_pc[s]  = rand_bits(2) == 0;
		src2_is_imm[s] = rand_bits(2) == 0;
	endtask

	task automatic move_up();
		valid[0]       = valid[1];
		instr_valid[0] = instr_valid[1];
		src1[0]        = src1[1];
		src2[0]        = src2[1];
		dst[0]         = dst[1];
		ticket[0]      = ticket[1];
		fu[0]          = fu[1];
		pc[0]          = pc[1];
		imm[0]         = imm[1];
		src1_is_pc[0]  = src1_is_pc[1];
		src2_is_imm[0] = src2_is_imm[1];
	endtask

	task automatic drive_inputs();
		// Queue pops issued slots and refills empty ones
		if (pop_1 && !pop_2) begin
			move_up();
			new_slot(1);
		end else if (pop_1) begin
			new_slot(0);
			new_slot(1);
		end
		for (int s = 0; s < 2; s++) begin
			if (!(valid[s] && instr_valid[s]))
				new_slot(s);
		end
		for (int w = 0; w < 2; w++) begin
			wb_valid[w]   = next_bit();
			wb_flushed[w] = rand_bits(3) == 0;
			wb_dst[w]     = issue_pkg::preg_t'(rand_bits(3));
			// Mostly the owning ticket and sometimes a stale one
			wb_ticket[w]  = (rand_bits(2) == 0) ? issue_pkg::ticket_t'(rand_bits(3)) :
				m_ticket[wb_dst[w]];
			wb_data[w]    = rand_bits(32);
		end
		for (int j = 0; j < issue_pkg::FU_NUM; j++) begin
			fu_valid[j]  = rand_bits(2) == 0;
			fu_dst[j]    = issue_pkg::preg_t'(rand_bits(3));
			fu_ticket[j] = (rand_bits(2) == 0) ? issue_pkg::ticket_t'(rand_bits(3)) :
				m_ticket[fu_dst[j]];
			fu_data[j]   = rand_bits(32);
			busy_fu[j]   = rand_bits(3) == 0;
		end
		flush_valid = rand_bits(5) == 0;
		flush_keep  = 8'(rand_bits(8));
	endtask

	initial begin
		clk = 1'b0;
		forever begin
			#10;
			clk = ~clk;
		end
	end

	// Model update at the clock edge from the inputs of the ending cycle
	always @(posedge clk or negedge rst_n) begin : model_update
		logic                   e1;
		logic                   e2;
		issue_pkg::word_t [3:0] ops;
		if (!rst_n) begin
			m_pending = '0;
			m_in_rob  = '0;
			pop_1     = 1'b0;
			pop_2     = 1'b0;
			for (int i = 0; i < issue_pkg::NUM_PREGS; i++) begin
				m_rf[i]     = '0;
				m_ticket[i] = '0;
				m_fu[i]     = '0;
			end
		end else begin
			expect_issue(e1, e2, ops);
			pop_1 = e1;
			pop_2 = e2;
			for (int i = 1; i < issue_pkg::NUM_PREGS; i++) begin
				if (flush_valid && !flush_keep[m_ticket[i]])
					m_pending[i] = 1'b0;
				else if ((e2 && int'(dst[1]) == i) || (e1 && int'(dst[0]) == i))
					m_pending[i] = 1'b1;
				else if (wb_valid[0] && int'(wb_dst[0]) == i && wb_ticket[0] == m_ticket[i])
					m_pending[i] = 1'b0;
				else if (wb_valid[1] && int'(wb_dst[1]) == i && wb_ticket[1] == m_ticket[i])
					m_pending[i] = 1'b0;
			end
			for (int i = 0; i < issue_pkg::NUM_PREGS; i++) begin
				if (e2 && int'(dst[1]) == i) begin
					m_in_rob[i] = 1'b0;
					m_ticket[i] = ticket[1];
					m_fu[i]     = fu[1];
				end else if (e1 && int'(dst[0]) == i) begin
					m_in_rob[i] = 1'b0;
					m_ticket[i] = ticket[0];
					m_fu[i]     = fu[0];
				end else begin
					for (int j = 0; j < issue_pkg::FU_NUM; j++) begin
						if (fu_valid[j] && int'(fu_dst[j]) == i && fu_ticket[j] == m_ticket[i])
							m_in_rob[i] = 1'b1;
					end
				end
			end
			// Commit writes with port 2 last
			for (int w = 0; w < 2; w++) begin
				if (wb_valid[w] && !wb_flushed[w])
					m_rf[wb_dst[w]] = wb_data[w];
			end
		end
	end

	always @(negedge clk) begin : compare_outputs
		logic                   e1;
		logic                   e2;
		issue_pkg::word_t [3:0] ops;
		if (rst_n) begin
			expect_issue(e1, e2, ops);
			check_value("issue_1", 32'(issue_1), 32'(e1));
			check_value("issue_2", 32'(issue_2), 32'(e2));
			check_value("op_a_1", op_a_1, ops[0]);
			check_value("op_b_1", op_b_1, ops[1]);
			check_value("op_a_2", op_a_2, ops[2]);
			check_value("op_b_2", op_b_2, ops[3]);
			// ROB is asked for the tickets recorded for the four sources
			check_value("rob_addr[0]", 32'(rob_addr[0]), 32'(m_ticket[src1[0]]));
			check_value("rob_addr[1]", 32'(rob_addr[1]), 32'(m_ticket[src2[0]]));
			check_value("rob_addr[2]", 32'(rob_addr[2]), 32'(m_ticket[src1[1]]));
			check_value("rob_addr[3]", 32'(rob_addr[3]), 32'(m_ticket[src2[1]]));
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$fatal(1, "timeout");
		end
	end

	initial begin
		lfsr        = 32'hcecac9d2;
		cycles      = 0;
		rst_n       = 1'b0;
		fu_valid    = '0;
		fu_dst      = '0;
		fu_ticket   = '0;
		fu_data     = '0;
		busy_fu     = '0;
		flush_valid = 1'b0;
		flush_keep  = '0;
		for (int s = 0; s < 2; s++) begin
			valid[s]       = 1'b0;
			instr_valid[s] = 1'b0;
			src1[s]        = '0;
			src2[s]        = '0;
			dst[s]         = '0;
			ticket[s]      = '0;
			fu[s]          = '0;
			pc[s]          = '0;
			imm[s]         = '0;
			src1_is_pc[s]  = 1'b0;
			src2_is_imm[s] = 1'b0;
			wb_valid[s]    = 1'b0;
			wb_flushed[s]  = 1'b0;
			wb_dst[s]      = '0;
			wb_ticket[s]   = '0;
			wb_data[s]     = '0;
		end
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
		for (int c = 0; c < NUM_CYCLES; c++) begin
			@(posedge clk);
			#2;
			drive_inputs();
		end
		@(negedge clk);
		#1;
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* issue_chk.sv */
// --------------------------------------------------------------------------
// Concurrent assertions on the issue stage top level, bound into every
// instance of issue_stage.
// --------------------------------------------------------------------------
`default_nettype none

module issue_chk (
	input wire            clk,
	input wire            rst_n,
	input wire            issue_1,
	input wire            issue_2,
	input issue_pkg::fu_t fu_1,
	input issue_pkg::fu_t fu_2
);

	// Younger slot only goes together with the older one
	a_in_order: assert property (@(posedge clk) disable iff (!rst_n)
		issue_2 |-> issue_1)
		else $error("issue_2 high while issue_1 is low");

	a_quiet_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> (!issue_1 && !issue_2))
		else $error("issue strobe high in the cycle after reset");

	// Both slots on one unit in the same cycle
	a_distinct_units: assert property (@(posedge clk) disable iff (!rst_n)
		issue_2 |-> (fu_1 != fu_2))
		else $error("dual issue to the same functional unit");

endmodule

bind issue_stage issue_chk i_chk (
	.clk     (clk),
	.rst_n   (rst_n),
	.issue_1 (issue_1),
	.issue_2 (issue_2),
	.fu_1    (fu_1),
	.fu_2    (fu_2)
);

`default_nettype wire

/* issue_stage.sv */
// --------------------------------------------------------------------------
// Top level of the issue stage. The decode queue pops a slot on each edge
// where issue_1 or issue_2 is high; operands are valid in the same cycle.
// --------------------------------------------------------------------------
`default_nettype none

module issue_stage (
	input  wire                                                  clk,
	input  wire                                                  rst_n,
	// Older slot
	input  wire                                                  valid_1,
	input  wire                                                  instr_valid_1,
	input  issue_pkg::preg_t                                     src1_1,
	input  issue_pkg::preg_t                                     src2_1,
	input  issue_pkg::preg_t                                     dst_1,
	input  issue_pkg::ticket_t                                   ticket_1,
	input  issue_pkg::fu_t                                       fu_1,
	input  issue_pkg::word_t                                     pc_1,
	input  issue_pkg::word_t                                     imm_1,
	input  wire                                                  src1_is_pc_1,
	input  wire                                                  src2_is_imm_1,
	// Younger slot
	input  wire                                                  valid_2,
	input  wire                                                  instr_valid_2,
	input  issue_pkg::preg_t                                     src1_2,
	input  issue_pkg::preg_t                                     src2_2,
	input  issue_pkg::preg_t                                     dst_2,
	input  issue_pkg::ticket_t                                   ticket_2,
	input  issue_pkg::fu_t                                       fu_2,
	input  issue_pkg::word_t                                     pc_2,
	input  issue_pkg::word_t                                     imm_2,
	input  wire                                                  src1_is_pc_2,
	input  wire                                                  src2_is_imm_2,
	output logic                                                 issue_1,
	output logic                                                 issue_2,
	output issue_pkg::word_t                                     op_a_1,
	output issue_pkg::word_t                                     op_b_1,
	output issue_pkg::word_t                                     op_a_2,
	output issue_pkg::word_t                                     op_b_2,
	// Commit
	input  wire                                                  wb_valid_1,
	input  wire                                                  wb_flushed_1,
	input  issue_pkg::preg_t                                     wb_dst_1,
	input  issue_pkg::ticket_t                                   wb_ticket_1,
	input  issue_pkg::word_t                                     wb_data_1,
	input  wire                                                  wb_valid_2,
	input  wire                                                  wb_flushed_2,
	input  issue_pkg::preg_t                                     wb_dst_2,
	input  issue_pkg::ticket_t                                   wb_ticket_2,
	input  issue_pkg::word_t                                     wb_data_2,
	// Functional-unit results and status
	input  wire                [issue_pkg::FU_NUM-1:0]           fu_valid,
	input  issue_pkg::preg_t   [issue_pkg::FU_NUM-1:0]           fu_dst,
	input  issue_pkg::ticket_t [issue_pkg::FU_NUM-1:0]           fu_ticket,
	input  issue_pkg::word_t   [issue_pkg::FU_NUM-1:0]           fu_data,
	input  wire                [issue_pkg::FU_NUM-1:0]           busy_fu,
	// ROB read, answered in the same cycle
	output issue_pkg::ticket_t [issue_pkg::RF_READ_PORTS-1:0]    rob_addr,
	input  issue_pkg::word_t   [issue_pkg::RF_READ_PORTS-1:0]    rob_data,
	input  wire                                                  flush_valid,
	input  wire                [issue_pkg::ROB_DEPTH-1:0]        flush_keep
);

	issue_pkg::word_t [issue_pkg::RF_READ_PORTS-1:0] rf_data;
	logic             [issue_pkg::RF_READ_PORTS-1:0] src_pending;
	logic             [issue_pkg::RF_READ_PORTS-1:0] src_in_rob;
	issue_pkg::fu_t   [issue_pkg::RF_READ_PORTS-1:0] src_fu;
	logic dst_pending_1;
	logic dst_pending_2;
	logic src1_ok_1;
	logic src2_ok_1;
	logic src1_ok_2;
	logic src2_ok_2;

	issue_regfile i_regfile (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en_1   (wb_valid_1 & ~wb_flushed_1),
		.wr_addr_1 (wb_dst_1),
		.wr_data_1 (wb_data_1),
		.wr_en_2   (wb_valid_2 & ~wb_flushed_2),
		.wr_addr_2 (wb_dst_2),
		.wr_data_2 (wb_data_2),
		.rd_addr   ({src2_2, src1_2, src2_1, src1_1}),
		.rd_data   (rf_data)
	);

	issue_scoreboard i_scoreboard (
		.clk           (clk),
		.rst_n         (rst_n),
		.src1_1        (src1_1),
		.src2_1        (src2_1),
		.dst_1         (dst_1),
		.src1_2        (src1_2),
		.src2_2        (src2_2),
		.dst_2         (dst_2),
		.ticket_1      (ticket_1),
		.fu_1          (fu_1),
		.ticket_2      (ticket_2),
		.fu_2          (fu_2),
		.issue_1       (issue_1),
		.issue_2       (issue_2),
		.fu_valid      (fu_valid),
		.fu_dst        (fu_dst),
		.fu_ticket     (fu_ticket),
		.wb_valid_1    (wb_valid_1),
		.wb_dst_1      (wb_dst_1),
		.wb_ticket_1   (wb_ticket_1),
		.wb_valid_2    (wb_valid_2),
		.wb_dst_2      (wb_dst_2),
		.wb_ticket_2   (wb_ticket_2),
		.flush_valid   (flush_valid),
		.flush_keep    (flush_keep),
		.src_pending   (src_pending),
		.src_in_rob    (src_in_rob),
		.src_fu        (src_fu),
		.src_ticket    (rob_addr),
		.dst_pending_1 (dst_pending_1),
		.dst_pending_2 (dst_pending_2)
	);

	issue_operand_sel i_opsel_1 (
		.src1 (src1_1), .src2 (src2_1), .pc (pc_1), .imm (imm_1),
		.src1_is_pc   (src1_is_pc_1),
		.src2_is_imm  (src2_is_imm_1),
		.src1_pending (src_pending[0]),
		.src2_pending (src_pending[1]),
		.src1_in_rob  (src_in_rob[0]),
		.src2_in_rob  (src_in_rob[1]),
		.src1_fu      (src_fu[0]),
		.src2_fu      (src_fu[1]),
		.rf_data_1    (rf_data[0]),
		.rf_data_2    (rf_data[1]),
		.rob_data_1   (rob_data[0]),
		.rob_data_2   (rob_data[1]),
		.fu_valid     (fu_valid),
		.fu_dst       (fu_dst),
		.fu_data      (fu_data),
		.op_a         (op_a_1),
		.op_b         (op_b_1),
		.src1_ok      (src1_ok_1),
		.src2_ok      (src2_ok_1)
	);

	issue_operand_sel i_opsel_2 (
		.src1 (src1_2), .src2 (src2_2), .pc (pc_2), .imm (imm_2),
		.src1_is_pc   (src1_is_pc_2),
		.src2_is_imm  (src2_is_imm_2),
		.src1_pending (src_pending[2]),
		.src2_pending (src_pending[3]),
		.src1_in_rob  (src_in_rob[2]),
		.src2_in_rob  (src_in_rob[3]),
		.src1_fu      (src_fu[2]),
		.src2_fu      (src_fu[3]),
		.rf_data_1    (rf_data[2]),
		.rf_data_2    (rf_data[3]),
		.rob_data_1   (rob_data[2]),
		.rob_data_2   (rob_data[3]),
		.fu_valid     (fu_valid),
		.fu_dst       (fu_dst),
		.fu_data      (fu_data),
		.op_a         (op_a_2),
		.op_b         (op_b_2),
		.src1_ok      (src1_ok_2),
		.src2_ok      (src2_ok_2)
	);

	issue_ctrl i_ctrl (
		.valid_1       (valid_1),
		.instr_valid_1 (instr_valid_1),
		.valid_2       (valid_2),
		.instr_valid_2 (instr_valid_2),
		.fu_1          (fu_1),
		.fu_2          (fu_2),
		.busy_fu       (busy_fu),
		.dst_pending_1 (dst_pending_1),
		.dst_pending_2 (dst_pending_2),
		.src1_ok_1     (src1_ok_1),
		.src2_ok_1     (src2_ok_1),
		.src1_ok_2     (src1_ok_2),
		.src2_ok_2     (src2_ok_2),
		.src1_2        (src1_2),
		.src2_2        (src2_2),
		.dst_1         (dst_1),
		.issue_1       (issue_1),
		.issue_2       (issue_2)
	);

endmodule

`default_nettype wire

/* issue_ctrl.sv */
// --------------------------------------------------------------------------
// In-order dual-issue decision. Slot 1 issues on its own checks, slot 2
// only together with slot 1 and free of conflicts with it.
// --------------------------------------------------------------------------
`default_nettype none

module issue_ctrl (
	input  wire                                   valid_1,
	input  wire                                   instr_valid_1,
	input  wire                                   valid_2,
	input  wire                                   instr_valid_2,
	input  issue_pkg::fu_t                        fu_1,
	input  issue_pkg::fu_t                        fu_2,
	input  wire        [issue_pkg::FU_NUM-1:0]    busy_fu,
	input  wire                                   dst_pending_1,
	input  wire                                   dst_pending_2,
	input  wire                                   src1_ok_1,
	input  wire                                   src2_ok_1,
	input  wire                                   src1_ok_2,
	input  wire                                   src2_ok_2,
	input  issue_pkg::preg_t                      src1_2,
	input  issue_pkg::preg_t                      src2_2,
	input  issue_pkg::preg_t                      dst_1,
	output logic                                  issue_1,
	output logic                                  issue_2
);

	logic own_ok_1;
	logic own_ok_2;
	logic dep_on_1;
	logic same_fu;

	// Checks each slot makes on its own
	assign own_ok_1 = valid_1 & instr_valid_1 & ~busy_fu[fu_1] & ~dst_pending_1 &
		src1_ok_1 & src2_ok_1;
	assign own_ok_2 = valid_2 & instr_valid_2 & ~busy_fu[fu_2] & ~dst_pending_2 &
		src1_ok_2 & src2_ok_2;

	// Slot 2 reads what slot 1 is about to produce
	assign dep_on_1 = (dst_1 != '0) & ((src1_2 == dst_1) | (src2_2 == dst_1));
	assign same_fu  = (fu_1 == fu_2);

	assign issue_1 = own_ok_1;
	assign issue_2 = issue_1 & own_ok_2 & ~dep_on_1 & ~same_fu;

endmodule

`default_nettype wire

/* issue_operand_sel.sv */
// --------------------------------------------------------------------------
// Operand selection for one instruction: pc or immediate, register file,
// ROB or a result bus. Also flags whether each source is ready.
// --------------------------------------------------------------------------
`default_nettype none

module issue_operand_sel (
	input  issue_pkg::preg_t                              src1,
	input  issue_pkg::preg_t                              src2,
	input  issue_pkg::word_t                              pc,
	input  issue_pkg::word_t                              imm,
	input  wire                                           src1_is_pc,
	input  wire                                           src2_is_imm,
	input  wire                                           src1_pending,
	input  wire                                           src2_pending,
	input  wire                                           src1_in_rob,
	input  wire                                           src2_in_rob,
	input  issue_pkg::fu_t                                src1_fu,
	input  issue_pkg::fu_t                                src2_fu,
	input  issue_pkg::word_t                              rf_data_1,
	input  issue_pkg::word_t                              rf_data_2,
	input  issue_pkg::word_t                              rob_data_1,
	input  issue_pkg::word_t                              rob_data_2,
	input  wire              [issue_pkg::FU_NUM-1:0]      fu_valid,
	input  issue_pkg::preg_t [issue_pkg::FU_NUM-1:0]      fu_dst,
	input  issue_pkg::word_t [issue_pkg::FU_NUM-1:0]      fu_data,
	output issue_pkg::word_t                              op_a,
	output issue_pkg::word_t                              op_b,
	output logic                                          src1_ok,
	output logic                                          src2_ok
);

	function automatic void pick(
		input  logic             special,
		input  issue_pkg::word_t special_val,
		input  issue_pkg::preg_t src,
		input  logic             pending,
		input  logic             in_rob,
		input  issue_pkg::fu_t   unit,
		input  issue_pkg::word_t rf_val,
		input  issue_pkg::word_t rob_val,
		output logic             ok,
		output issue_pkg::word_t val
	);
		ok  = 1'b1;
		val = rf_val;
		if (special) begin
			val = special_val;
		end else if (!pending) begin
			val = rf_val;
		end else if (in_rob) begin
			val = rob_val;
		end else if (fu_valid[unit] && fu_dst[unit] == src) begin
			// Result appears on the bus this cycle
			val = fu_data[unit];
		end else begin
			ok = 1'b0;
		end
	endfunction

	always_comb begin
		pick(src1_is_pc, pc, src1, src1_pending, src1_in_rob, src1_fu,
			rf_data_1, rob_data_1, src1_ok, op_a);
		pick(src2_is_imm, imm, src2, src2_pending, src2_in_rob, src2_fu,
			rf_data_2, rob_data_2, src2_ok, op_b);
	end

endmodule

`default_nettype wire

/* issue_scoreboard.sv */
// --------------------------------------------------------------------------
// Scoreboard of the physical registers: pending, ticket, unit and in-ROB
// per entry. Updated by issue, results, commit and flush at the clock edge.
// --------------------------------------------------------------------------
`default_nettype none

module issue_scoreboard (
	input  wire                                                  clk,
	input  wire                                                  rst_n,
	// Source and destination indices of both slots
	input  issue_pkg::preg_t                                     src1_1,
	input  issue_pkg::preg_t                                     src2_1,
	input  issue_pkg::preg_t                                     dst_1,
	input  issue_pkg::preg_t                                     src1_2,
	input  issue_pkg::preg_t                                     src2_2,
	input  issue_pkg::preg_t                                     dst_2,
	input  issue_pkg::ticket_t                                   ticket_1,
	input  issue_pkg::fu_t                                       fu_1,
	input  issue_pkg::ticket_t                                   ticket_2,
	input  issue_pkg::fu_t                                       fu_2,
	input  wire                                                  issue_1,
	input  wire                                                  issue_2,
	// Functional-unit results
	input  wire              [issue_pkg::FU_NUM-1:0]             fu_valid,
	input  issue_pkg::preg_t [issue_pkg::FU_NUM-1:0]             fu_dst,
	input  issue_pkg::ticket_t [issue_pkg::FU_NUM-1:0]           fu_ticket,
	// Commit
	input  wire                                                  wb_valid_1,
	input  issue_pkg::preg_t                                     wb_dst_1,
	input  issue_pkg::ticket_t                                   wb_ticket_1,
	input  wire                                                  wb_valid_2,
	input  issue_pkg::preg_t                                     wb_dst_2,
	input  issue_pkg::ticket_t                                   wb_ticket_2,
	input  wire                                                  flush_valid,
	input  wire              [issue_pkg::ROB_DEPTH-1:0]          flush_keep,
	// Per source, in the order src1_1, src2_1, src1_2, src2_2
	output logic             [issue_pkg::RF_READ_PORTS-1:0]      src_pending,
	output logic             [issue_pkg::RF_READ_PORTS-1:0]      src_in_rob,
	output issue_pkg::fu_t   [issue_pkg::RF_READ_PORTS-1:0]      src_fu,
	output issue_pkg::ticket_t [issue_pkg::RF_READ_PORTS-1:0]    src_ticket,
	output logic                                                 dst_pending_1,
	output logic                                                 dst_pending_2
);

	logic [issue_pkg::NUM_PREGS-1:0] pending;
	logic [issue_pkg::NUM_PREGS-1:0] in_rob;
	issue_pkg::ticket_t              ticket [issue_pkg::NUM_PREGS];
	issue_pkg::fu_t                  fu     [issue_pkg::NUM_PREGS];
	issue_pkg::preg_t                src    [issue_pkg::RF_READ_PORTS];

	assign src[0] = src1_1;
	assign src[1] = src2_1;
	assign src[2] = src1_2;
	assign src[3] = src2_2;

	always_comb begin
		for (int s = 0; s < issue_pkg::RF_READ_PORTS; s++) begin
			src_pending[s] = pending[src[s]];
			src_in_rob[s]  = in_rob[src[s]];
			src_fu[s]      = fu[src[s]];
			src_ticket[s]  = ticket[src[s]];
		end
	end

	assign dst_pending_1 = pending[dst_1];
	assign dst_pending_2 = pending[dst_2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= '0;
			in_rob  <= '0;
			for (int i = 0; i < issue_pkg::NUM_PREGS; i++) begin
				ticket[i] <= '0;
				fu[i]     <= '0;
			end
		end else begin
			// Entry 0 is the zero register and never waits
			pending[0] <= 1'b0;
			for (int i = 1; i < issue_pkg::NUM_PREGS; i++) begin
				if (flush_valid && !flush_keep[ticket[i]]) begin
					pending[i] <= 1'b0;
				end else if (issue_2 && dst_2 == i) begin
					pending[i] <= 1'b1;
				end else if (issue_1 && dst_1 == i) begin
					pending[i] <= 1'b1;
				end else if (wb_valid_1 && wb_dst_1 == i && wb_ticket_1 == ticket[i]) begin
					pending[i] <= 1'b0;
				end else if (wb_valid_2 && wb_dst_2 == i && wb_ticket_2 == ticket[i]) begin
					pending[i] <= 1'b0;
				end
			end

			for (int i = 0; i < issue_pkg::NUM_PREGS; i++) begin
				if (issue_2 && dst_2 == i) begin
					in_rob[i] <= 1'b0;
					ticket[i] <= ticket_2;
					fu[i]     <= fu_2;
				end else if (issue_1 && dst_1 == i) begin
					in_rob[i] <= 1'b0;
					ticket[i] <= ticket_1;
					fu[i]     <= fu_1;
				end else begin
					// A result for the current owner has reached the ROB
					for (int j = 0; j < issue_pkg::FU_NUM; j++) begin
						if (fu_valid[j] && fu_dst[j] == i && fu_ticket[j] == ticket[i]) begin
							in_rob[i] <= 1'b1;
						end
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* issue_regfile.sv */
// --------------------------------------------------------------------------
// Physical register file with two commit write ports and four
// combinational read ports, one per source of the two issue slots.
// --------------------------------------------------------------------------
`default_nettype none

module issue_regfile (
	input  wire                                                  clk,
	input  wire                                                  rst_n,
	input  wire                                                  wr_en_1,
	input  issue_pkg::preg_t                                     wr_addr_1,
	input  issue_pkg::word_t                                     wr_data_1,
	input  wire                                                  wr_en_2,
	input  issue_pkg::preg_t                                     wr_addr_2,
	input  issue_pkg::word_t                                     wr_data_2,
	input  issue_pkg::preg_t [issue_pkg::RF_READ_PORTS-1:0]      rd_addr,
	output issue_pkg::word_t [issue_pkg::RF_READ_PORTS-1:0]      rd_data
);

	issue_pkg::word_t regs [issue_pkg::NUM_PREGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < issue_pkg::NUM_PREGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wr_en_1) begin
				regs[wr_addr_1] <= wr_data_1;
			end
			// Port 2 is written last, so it wins on the same register
			if (wr_en_2) begin
				regs[wr_addr_2] <= wr_data_2;
			end
		end
	end

	// No bypass of the writes in flight
	always_comb begin
		for (int r = 0; r < issue_pkg::RF_READ_PORTS; r++) begin
			rd_data[r] = regs[rd_addr[r]];
		end
	end

endmodule

`default_nettype wire

/* issue_pkg.sv */
// --------------------------------------------------------------------------
// Shared widths, counts, unit codes and types of the issue stage.
// RTL and testbench refer to them by scoped names.
// --------------------------------------------------------------------------
`default_nettype none

package issue_pkg;

	// Physical registers and scoreboard entries
	localparam int NUM_PREGS = 64;
	localparam int PREG_BITS = 6;

	// Data word
	localparam int XLEN = 32;

	// Reorder buffer tickets, one flush mask bit per ticket
	localparam int ROB_BITS  = 3;
	localparam int ROB_DEPTH = 8;

	// Functional units
	localparam int FU_NUM  = 4;
	localparam int FU_BITS = 2;

	// Unit codes
	localparam logic [FU_BITS-1:0] FU_LSU = 2'd0;
	localparam logic [FU_BITS-1:0] FU_FPU = 2'd1;
	localparam logic [FU_BITS-1:0] FU_INT = 2'd2;
	localparam logic [FU_BITS-1:0] FU_BR  = 2'd3;

	// Two sources for each of the two slots
	localparam int RF_READ_PORTS = 4;

	typedef logic [PREG_BITS-1:0] preg_t;
	typedef logic [ROB_BITS-1:0]  ticket_t;
	typedef logic [FU_BITS-1:0]   fu_t;
	typedef logic [XLEN-1:0]      word_t;

endpackage

`default_nettype wire
